//--- filelist.f
+incdir+tests
rtl/regAddrPkg.sv
rtl/operandFieldSelect.sv
rtl/bankedAddrDecode.sv
rtl/hazardAddrPipe.sv
rtl/addressPath.sv
tests/addressPathTb.sv

//--- Makefile
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f filelist.f \
		--top-module addressPathTb -Mdir $(OBJ_DIR) -o addressPathSim
	./$(OBJ_DIR)/addressPathSim

clean:
	rm -rf $(OBJ_DIR)

//--- tests/addrRefModel.svh
`ifndef ADDR_REF_MODEL_SVH
`define ADDR_REF_MODEL_SVH

// ===========================================================================
// Register field per port
// ===========================================================================

// Rs wins for register-shifted register forms
function automatic logic [3:0] ra1FieldFor(input logic [31:0] instr, input logic mult,
                                           input logic [1:0] regSrc, input logic [3:0] rz);
  if (!mult && rz[2] && rz[3]) begin
    return instr[11:8];
  end
  return mult ? instr[3:0] : (regSrc[0] ? 4'd15 : instr[19:16]);
endfunction

function automatic logic [3:0] ra2FieldFor(input logic [31:0] instr, input logic mult,
                                           input logic [1:0] regSrc);
  return mult ? instr[11:8] : (regSrc[1] ? instr[15:12] : instr[3:0]);
endfunction

function automatic logic [3:0] wa3FieldFor(input logic [31:0] instr, input logic mult);
  return mult ? instr[19:16] : instr[15:12];
endfunction

// ===========================================================================
// Banked register map
// ===========================================================================

function automatic logic [4:0] bankedIndex(input logic [3:0] f, input logic scr,
                                           input logic [4:0] mode);
  logic [4:0] lrOfs;
  lrOfs = (f == 4'd14) ? 5'd1 : 5'd0;
  if (scr) begin
    return 5'd31;
  end
  // fiq r8 lands on 16
  if (f >= 4'd8 && f <= 4'd12 && mode == 5'b10001) begin
    return {1'b0, f} + 5'd8;
  end
  if (f == 4'd13 || f == 4'd14) begin
    case (mode)
      5'b10001: return 5'd21 + lrOfs;
      5'b10010: return 5'd23 + lrOfs;
      5'b10011: return 5'd25 + lrOfs;
      5'b10111: return 5'd27 + lrOfs;
      5'b11011: return 5'd29 + lrOfs;
      // User, system and illegal codes
      default: return {1'b0, f};
    endcase
  end
  return {1'b0, f};
endfunction

function automatic logic [31:0] indexToOneHot(input logic [4:0] idx);
  logic [31:0] sel;
  sel = '0;
  sel[idx] = 1'b1;
  return sel;
endfunction

`endif

//--- tests/addressPathTb.sv
`timescale 1ns/1ps

module addressPathTb;

  `include "addrRefModel.svh"

  localparam int ClkPeriod = 8;
  localparam int RandomCycles = 2000;
  // 7 modes of 64 cycles with each register held for 4 cycles
  localparam int DirectedCycles = 448;
  localparam int TimeoutNs = (RandomCycles + DirectedCycles + 100) * ClkPeriod;

  logic clk = 1'b0;
  logic arstN;
  logic [31:0] instrD, instrE;
  logic multSelectD, aluSrcD;
  logic [1:0] regSrcD;
  logic [3:0] regFileRzD;
  logic [7:0] cpsr8W;
  logic stallE, stallM, flushM, stallW, flushW;
  logic [31:0] ra1D, ra2D, rdLoE, wa3W;
  logic match1DE, match2DE, match1EM, match2EM, match1EW, match2EW;

  // user, system, fiq, irq, svc, abort, undef
  logic [4:0] legalModes [0:6] = '{5'b10000, 5'b11111, 5'b10001, 5'b10010,
                                   5'b10011, 5'b10111, 5'b11011};

  // Expected decode-stage selects
  logic [31:0] expRa1D, expRa2D, expWa3D, expRdLoE;
  logic expRmImmD;
  // Shadow pipeline
  logic [31:0] shWa3E, shRa1E, shRa2E, shWa3M, shWa3W;
  logic shRmImmE, shMatch1EM, shMatch2EM;
  logic expMatch1DE, expMatch2DE, expMatch1EW, expMatch2EW;

  addressPath i_addressPath (
    .clk(clk), .arstN(arstN), .instrD(instrD), .instrE(instrE),
    .multSelectD(multSelectD), .aluSrcD(aluSrcD), .regSrcD(regSrcD),
    .regFileRzD(regFileRzD), .cpsr8W(cpsr8W), .stallE(stallE), .stallM(stallM),
    .flushM(flushM), .stallW(stallW), .flushW(flushW), .ra1D(ra1D), .ra2D(ra2D),
    .rdLoE(rdLoE), .wa3W(wa3W), .match1DE(match1DE), .match2DE(match2DE),
    .match1EM(match1EM), .match2EM(match2EM), .match1EW(match1EW), .match2EW(match2EW)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // ========================================================================
  // Expected values
  // ========================================================================

  assign expRa1D = indexToOneHot(bankedIndex(ra1FieldFor(instrD, multSelectD, regSrcD,
                                                         regFileRzD),
                                             regFileRzD[0], cpsr8W[4:0]));
  assign expRa2D = indexToOneHot(bankedIndex(ra2FieldFor(instrD, multSelectD, regSrcD),
                                             regFileRzD[1], cpsr8W[4:0]));
  assign expWa3D = indexToOneHot(bankedIndex(wa3FieldFor(instrD, multSelectD),
                                             regFileRzD[2], cpsr8W[4:0]));
  // RdLo never takes the scratch slot
  assign expRdLoE = indexToOneHot(bankedIndex(instrE[15:12], 1'b0, cpsr8W[4:0]));
  assign expRmImmD = aluSrcD && !multSelectD && !regSrcD[1];

  assign expMatch1DE = (shWa3E == expRa1D) && (shWa3E != '0);
  assign expMatch2DE = (shWa3E == expRa2D) && (shWa3E != '0) && !expRmImmD;
  assign expMatch1EW = (shWa3W == shRa1E) && (shWa3W != '0);
  assign expMatch2EW = (shWa3W == shRa2E) && (shWa3W != '0) && !shRmImmE;

  // Stage registers where flush beats stall
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {shWa3E, shRa1E, shRa2E, shWa3M, shWa3W} <= '0;
      {shRmImmE, shMatch1EM, shMatch2EM} <= '0;
    end else begin
      if (!stallE) begin
        shWa3E <= expWa3D;
        shRa1E <= expRa1D;
        shRa2E <= expRa2D;
        shRmImmE <= expRmImmD;
      end
      if (flushM) begin
        {shWa3M, shMatch1EM, shMatch2EM} <= '0;
      end else if (!stallM) begin
        shWa3M <= shWa3E;
        shMatch1EM <= expMatch1DE;
        shMatch2EM <= expMatch2DE;
      end
      if (flushW) begin
        shWa3W <= '0;
      end else if (!stallW) begin
        shWa3W <= shWa3M;
      end
    end
  end

  // ========================================================================
  // Checks
  // ========================================================================

  task automatic reportMismatch(input string sigName, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    $display("** Error at %0t: %s expected %h, got %h", $time, sigName, expVal, actVal);
    $display("ERRORS FOUND");
    $fatal(1, "output mismatch");
  endtask

  chkRa1D: assert property (@(posedge clk) disable iff (!arstN) ra1D == expRa1D)
    else reportMismatch("ra1D", $sampled(expRa1D), $sampled(ra1D));
  chkRa2D: assert property (@(posedge clk) disable iff (!arstN) ra2D == expRa2D)
    else reportMismatch("ra2D", $sampled(expRa2D), $sampled(ra2D));
  chkRdLoE: assert property (@(posedge clk) disable iff (!arstN) rdLoE == expRdLoE)
    else reportMismatch("rdLoE", $sampled(expRdLoE), $sampled(rdLoE));
  chkWa3W: assert property (@(posedge clk) disable iff (!arstN) wa3W == shWa3W)
    else reportMismatch("wa3W", $sampled(shWa3W), $sampled(wa3W));
  chkMatch1DE: assert property (@(posedge clk) disable iff (!arstN) match1DE == expMatch1DE)
    else reportMismatch("match1DE", 32'($sampled(expMatch1DE)), 32'($sampled(match1DE)));
  chkMatch2DE: assert property (@(posedge clk) disable iff (!arstN) match2DE == expMatch2DE)
    else reportMismatch("match2DE", 32'($sampled(expMatch2DE)), 32'($sampled(match2DE)));
  chkMatch1EM: assert property (@(posedge clk) disable iff (!arstN) match1EM == shMatch1EM)
    else reportMismatch("match1EM", 32'($sampled(shMatch1EM)), 32'($sampled(match1EM)));
  chkMatch2EM: assert property (@(posedge clk) disable iff (!arstN) match2EM == shMatch2EM)
    else reportMismatch("match2EM", 32'($sampled(shMatch2EM)), 32'($sampled(match2EM)));
  chkMatch1EW: assert property (@(posedge clk) disable iff (!arstN) match1EW == expMatch1EW)
    else reportMismatch("match1EW", 32'($sampled(expMatch1EW)), 32'($sampled(match1EW)));
  chkMatch2EW: assert property (@(posedge clk) disable iff (!arstN) match2EW == expMatch2EW)
    else reportMismatch("match2EW", 32'($sampled(expMatch2EW)), 32'($sampled(match2EW)));

  // ========================================================================
  // Stimulus
  // ========================================================================

  function automatic bit randChance(input int unsigned pct);
    return ($urandom % 100) < pct;
  endfunction

  task automatic randomizeInputs();
    logic [4:0] mode;
    // Mostly legal modes plus some illegal codes
    mode = randChance(12) ? 5'($urandom) : legalModes[3'($urandom % 7)];
    instrD <= $urandom;
    instrE <= $urandom;
    multSelectD <= randChance(30);
    aluSrcD <= randChance(50);
    regSrcD <= 2'($urandom);
    // Scratch and RSR flags kept rare so banking shows through
    regFileRzD <= {randChance(25), randChance(25), randChance(25), randChance(25)};
    cpsr8W <= {3'($urandom), mode};
    stallE <= randChance(20);
    stallM <= randChance(20);
    flushM <= randChance(20);
    stallW <= randChance(20);
    flushW <= randChance(20);
  endtask

  // Same register in Rn, Rm and Rd for 4 cycles
  task automatic applySameRegister(input int idx);
    logic [3:0] r;
    r = 4'((idx / 4) % 16);
    instrD <= {12'h000, r, r, r, r, r};
    instrE <= {16'h0000, r, 12'h000};
    multSelectD <= 1'b0;
    // Toggles rmImmD suppression
    aluSrcD <= idx[0];
    regSrcD <= 2'b00;
    regFileRzD <= 4'b0000;
    cpsr8W <= {3'b000, legalModes[3'((idx / 64) % 7)]};
    {stallE, stallM, flushM, stallW, flushW} <= '0;
  endtask

  initial begin
    void'($urandom(32'ha6c5_8e03));
    arstN <= 1'b0;
    instrD <= '0;
    instrE <= '0;
    {multSelectD, aluSrcD, regSrcD, regFileRzD} <= '0;
    cpsr8W <= 8'h10;
    {stallE, stallM, flushM, stallW, flushW} <= '0;
    repeat (4) @(posedge clk);
    arstN <= 1'b1;
    for (int i = 0; i < RandomCycles; i++) begin
      @(posedge clk);
      randomizeInputs();
    end
    for (int i = 0; i < DirectedCycles; i++) begin
      @(posedge clk);
      applySameRegister(i);
    end
    // Let the last values reach writeback
    repeat (4) @(posedge clk);
    $display("NO ERRORS");
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("Timeout: the test did not finish within the expected time");
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- rtl/addressPath.sv
`timescale 1ns/1ps

module addressPath (
  input  logic clk,
  input  logic arstN,
  // Instruction words in decode and execute
  input  logic [31:0] instrD,
  input  logic [31:0] instrE,
  // Controller selects
  input  logic multSelectD,
  input  logic aluSrcD,
  input  logic [1:0] regSrcD,
  input  logic [3:0] regFileRzD,
  input  logic [7:0] cpsr8W,
  // Hazard unit controls
  input  logic stallE,
  input  logic stallM,
  input  logic flushM,
  input  logic stallW,
  input  logic flushW,
  // Register file selects
  output regAddrPkg::physSelT ra1D,
  output regAddrPkg::physSelT ra2D,
  output regAddrPkg::physSelT rdLoE,
  output regAddrPkg::physSelT wa3W,
  // To the hazard unit
  output logic match1DE,
  output logic match2DE,
  output logic match1EM,
  output logic match2EM,
  output logic match1EW,
  output logic match2EW
);
  import regAddrPkg::*;

  archRegT [NumAddrPorts-1:0] fieldSel;
  logic [NumAddrPorts-1:0] scratchSel;
  modeOneHotT modeOneHot;
  logic rmImmD;
  // One decoded select per port
  physSelT [NumAddrPorts-1:0] physSel;

  // Fields, scratch flags and mode
  operandFieldSelect i_operandFieldSelect (
    .instrD(instrD),
    .instrE(instrE),
    .multSelectD(multSelectD),
    .aluSrcD(aluSrcD),
    .regSrcD(regSrcD),
    .regFileRzD(regFileRzD),
    .cpsr8W(cpsr8W),
    .fieldSel(fieldSel),
    .scratchSel(scratchSel),
    .modeOneHot(modeOneHot),
    .rmImmD(rmImmD)
  );

  // RA1, RA2, WA3 and RdLo decoders
  for (genvar k = 0; k < NumAddrPorts; k++) begin : genDecode
    bankedAddrDecode i_bankedAddrDecode (
      .field(fieldSel[k]),
      .scratch(scratchSel[k]),
      .modeOneHot(modeOneHot),
      .physSel(physSel[k])
    );
  end

  // Read selects and RdLo go straight out
  assign ra1D = physSel[PortRa1];
  assign ra2D = physSel[PortRa2];
  assign rdLoE = physSel[PortRdLo];

  // Destination pipeline and match logic
  hazardAddrPipe i_hazardAddrPipe (
    .clk(clk),
    .arstN(arstN),
    .stallE(stallE),
    .stallM(stallM),
    .flushM(flushM),
    .stallW(stallW),
    .flushW(flushW),
    .ra1D(physSel[PortRa1]),
    .ra2D(physSel[PortRa2]),
    .wa3D(physSel[PortWa3]),
    .rmImmD(rmImmD),
    .wa3W(wa3W),
    .match1DE(match1DE),
    .match2DE(match2DE),
    .match1EM(match1EM),
    .match2EM(match2EM),
    .match1EW(match1EW),
    .match2EW(match2EW)
  );

endmodule

//--- rtl/hazardAddrPipe.sv
`timescale 1ns/1ps

module hazardAddrPipe (
  input  logic clk,
  input  logic arstN,
  // Hazard unit controls
  input  logic stallE,
  input  logic stallM,
  input  logic flushM,
  input  logic stallW,
  input  logic flushW,
  // Decode-stage selects
  input  regAddrPkg::physSelT ra1D,
  input  regAddrPkg::physSelT ra2D,
  input  regAddrPkg::physSelT wa3D,
  input  logic rmImmD,
  // Writeback destination to the register file
  output regAddrPkg::physSelT wa3W,
  // Forwarding and stall matches
  output logic match1DE,
  output logic match2DE,
  output logic match1EM,
  output logic match2EM,
  output logic match1EW,
  output logic match2EW
);
  import regAddrPkg::*;

  physSelT wa3E;
  physSelT ra1E;
  physSelT ra2E;
  // Execute copy of the immediate flag
  logic rmImmE;
  physSelT wa3M;

  // =========================================================================
  // Execute stage
  // =========================================================================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wa3E <= '0;
      ra1E <= '0;
      ra2E <= '0;
      rmImmE <= 1'b0;
    end else if (!stallE) begin
      wa3E <= wa3D;
      ra1E <= ra1D;
      ra2E <= ra2D;
      rmImmE <= rmImmD;
    end
  end

  // Decode reads against the instruction now in execute
  // Zero select is no register and never matches
  assign match1DE = (wa3E == ra1D) && (wa3E != '0);
  // Immediate in bits 3:0 is not a register read
  assign match2DE = (wa3E == ra2D) && (wa3E != '0) && !rmImmD;

  // =========================================================================
  // Memory stage
  // =========================================================================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wa3M <= '0;
      match1EM <= 1'b0;
      match2EM <= 1'b0;
    end else if (flushM) begin
      // Bubble, flush wins over a stall
      wa3M <= '0;
      match1EM <= 1'b0;
      match2EM <= 1'b0;
    end else if (!stallM) begin
      wa3M <= wa3E;
      // Decode matches move along with their instruction
      match1EM <= match1DE;
      match2EM <= match2DE;
    end
  end

  // =========================================================================
  // Writeback stage
  // =========================================================================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wa3W <= '0;
    end else if (flushW) begin
      wa3W <= '0;
    end else if (!stallW) begin
      wa3W <= wa3M;
    end
  end

  // Writeback result against execute operands
  assign match1EW = (wa3W == ra1E) && (wa3W != '0);
  // Same suppression as decode, carried in rmImmE
  assign match2EW = (wa3W == ra2E) && (wa3W != '0) && !rmImmE;

  // =========================================================================
  // Checks
  // =========================================================================

  // Flushed memory stage drives no forwarding next cycle
  flushMBubble: assert property (
    @(posedge clk) disable iff (!arstN)
    flushM |=> (wa3M == '0) && !match1EM && !match2EM
  ) else $error("memory stage not empty after flushM");

  // Flushed writeback stage cannot match the execute operands
  flushWBubble: assert property (
    @(posedge clk) disable iff (!arstN)
    flushW |=> (wa3W == '0) && !match1EW && !match2EW
  ) else $error("writeback stage not empty after flushW");

  // At most one register written per cycle
  wa3WOneHot: assert property (
    @(posedge clk) disable iff (!arstN)
    $onehot0(wa3W)
  ) else $error("wa3W %h selects more than one register", wa3W);

endmodule

//--- rtl/bankedAddrDecode.sv
`timescale 1ns/1ps

module bankedAddrDecode (
  input  regAddrPkg::archRegT field,
  // Force the scratch register
  input  logic scratch,
  input  regAddrPkg::modeOneHotT modeOneHot,
  output regAddrPkg::physSelT physSel
);
  import regAddrPkg::*;

  // Field zero-extended to the physical index width
  logic [PhysIdxWidth-1:0] fieldIdx;
  logic [PhysIdxWidth-1:0] physIdx;
  // r8 to r12, banked only in fiq
  logic isFiqBanked;
  // r13 and r14, banked in every privileged mode
  logic isModeBanked;
  // Second slot of a two-entry bank
  logic lrOfs;

  assign fieldIdx = PhysIdxWidth'(field);
  assign isFiqBanked = (field >= FiqLowReg) && (field <= FiqHighReg);
  assign isModeBanked = (field == SpReg) || (field == LrReg);
  assign lrOfs = (field == LrReg);

  // =========================================================================
  // Banking rule
  // =========================================================================

  always_comb begin
    // Default is the user set, also for r0-r7, r15 and unknown modes
    physIdx = PhysUserBase + fieldIdx;
    if (scratch) begin
      physIdx = PhysScratch;
    end else if (isFiqBanked && modeOneHot[ModeBitFiq]) begin
      physIdx = PhysFiqR8Base + fieldIdx - PhysIdxWidth'(FiqLowReg);
    end else if (isModeBanked) begin
      // SP and LR per privileged mode
      if (modeOneHot[ModeBitFiq]) begin
        physIdx = PhysFiqR13Base + PhysIdxWidth'(lrOfs);
      end else if (modeOneHot[ModeBitIrq]) begin
        physIdx = PhysIrqR13Base + PhysIdxWidth'(lrOfs);
      end else if (modeOneHot[ModeBitSvc]) begin
        physIdx = PhysSvcR13Base + PhysIdxWidth'(lrOfs);
      end else if (modeOneHot[ModeBitAbort]) begin
        physIdx = PhysAbortR13Base + PhysIdxWidth'(lrOfs);
      end else if (modeOneHot[ModeBitUndef]) begin
        physIdx = PhysUndefR13Base + PhysIdxWidth'(lrOfs);
      end
      // userSys keeps the default
    end
  end

  // Index to one-hot word line
  assign physSel = physSelT'(1) << physIdx;

  // Register file write enable relies on a single word line
  always_comb begin
    if (!$isunknown({field, scratch, modeOneHot})) begin
      assert ($onehot(physSel))
        else $error("physSel %h is not one-hot for field %0d", physSel, field);
    end
  end

endmodule

//--- rtl/operandFieldSelect.sv
`timescale 1ns/1ps

module operandFieldSelect (
  // Decode and execute instruction words
  input  logic [31:0] instrD,
  input  logic [31:0] instrE,
  // Controller decode-stage selects
  input  logic multSelectD,
  input  logic aluSrcD,
  input  logic [1:0] regSrcD,
  input  logic [3:0] regFileRzD,
  // Mode as seen from writeback
  input  logic [7:0] cpsr8W,
  // One field and scratch flag per decoder port
  output regAddrPkg::archRegT [regAddrPkg::NumAddrPorts-1:0] fieldSel,
  output logic [regAddrPkg::NumAddrPorts-1:0] scratchSel,
  output regAddrPkg::modeOneHotT modeOneHot,
  output logic rmImmD
);
  import regAddrPkg::*;

  logic [ModeCodeWidth-1:0] modeCode;
  // Rn or PC or Rm before the RSR override
  archRegT rnField;
  archRegT ra1Field;
  archRegT ra2Field;
  archRegT wa3Field;
  // Register-shifted register form
  logic rsrD;

  // =========================================================================
  // Mode decode
  // =========================================================================

  assign modeCode = cpsr8W[ModeCodeWidth-1:0];

  // User and system share one register set
  assign modeOneHot[ModeBitUserSys] = (modeCode == ModeUser) || (modeCode == ModeSystem);
  assign modeOneHot[ModeBitFiq] = (modeCode == ModeFiq);
  assign modeOneHot[ModeBitIrq] = (modeCode == ModeIrq);
  assign modeOneHot[ModeBitSvc] = (modeCode == ModeSvc);
  assign modeOneHot[ModeBitAbort] = (modeCode == ModeAbort);
  assign modeOneHot[ModeBitUndef] = (modeCode == ModeUndef);
  // Illegal codes leave every bit clear, the decoders then fall back to user

  // =========================================================================
  // Field selection
  // =========================================================================

  // Shift amount comes from Rs
  assign rsrD = !multSelectD && regFileRzD[2] && regFileRzD[3];

  // RA1, multiply reads Rm, PC-relative forms read r15
  always_comb begin
    if (multSelectD) begin
      rnField = instrD[3:0];
    end else if (regSrcD[0]) begin
      rnField = PcReg;
    end else begin
      rnField = instrD[19:16];
    end
  end

  // Rs overrides the first read port
  assign ra1Field = rsrD ? instrD[11:8] : rnField;

  // RA2, multiply reads Rs, stores read Rd
  always_comb begin
    if (multSelectD) begin
      ra2Field = instrD[11:8];
    end else if (regSrcD[1]) begin
      ra2Field = instrD[15:12];
    end else begin
      ra2Field = instrD[3:0];
    end
  end

  // Multiply writes Rd from bits 19:16
  assign wa3Field = multSelectD ? instrD[19:16] : instrD[15:12];

  assign fieldSel[PortRa1] = ra1Field;
  assign fieldSel[PortRa2] = ra2Field;
  assign fieldSel[PortWa3] = wa3Field;
  // RdLo of a long multiply already sitting in execute
  assign fieldSel[PortRdLo] = instrE[15:12];

  // Scratch flags from the controller
  assign scratchSel[PortRa1] = regFileRzD[0];
  assign scratchSel[PortRa2] = regFileRzD[1];
  assign scratchSel[PortWa3] = regFileRzD[2];
  assign scratchSel[PortRdLo] = 1'b0;

  // Bits 3:0 hold an immediate, so RA2 must never match
  assign rmImmD = aluSrcD && !multSelectD && !regSrcD[1];

  // Mode codes in the package must stay distinct
  always_comb begin
    if (!$isunknown(modeCode)) begin
      assert ($onehot0(modeOneHot))
        else $error("modeOneHot %b has more than one bit set", modeOneHot);
    end
  end

endmodule

//--- rtl/regAddrPkg.sv
package regAddrPkg;

  // =========================================================================
  // Widths
  // =========================================================================

  // Architectural register field as it appears in the instruction
  localparam int ArchRegWidth = 4;
  // Banked register file size, user set plus banks plus scratch
  localparam int PhysRegCount = 32;
  localparam int PhysIdxWidth = $clog2(PhysRegCount);
  // userSys, fiq, irq, svc, abort, undef
  localparam int NumModes = 6;
  // Low bits of CPSR holding the mode
  localparam int ModeCodeWidth = 5;

  typedef logic [ArchRegWidth-1:0] archRegT;
  // All zeros means no register
  typedef logic [PhysRegCount-1:0] physSelT;
  typedef logic [NumModes-1:0] modeOneHotT;

  // =========================================================================
  // Decoder ports
  // =========================================================================

  localparam int NumAddrPorts = 4;
  localparam int PortRa1 = 0;
  localparam int PortRa2 = 1;
  localparam int PortWa3 = 2;
  // Long multiply low destination, decoded in execute
  localparam int PortRdLo = 3;

  // =========================================================================
  // Processor modes
  // =========================================================================

  // CPSR[4:0] encodings
  localparam logic [ModeCodeWidth-1:0] ModeUser = 5'b10000;
  localparam logic [ModeCodeWidth-1:0] ModeSystem = 5'b11111;
  localparam logic [ModeCodeWidth-1:0] ModeFiq = 5'b10001;
  localparam logic [ModeCodeWidth-1:0] ModeIrq = 5'b10010;
  localparam logic [ModeCodeWidth-1:0] ModeSvc = 5'b10011;
  localparam logic [ModeCodeWidth-1:0] ModeAbort = 5'b10111;
  localparam logic [ModeCodeWidth-1:0] ModeUndef = 5'b11011;

  // Bit positions inside modeOneHotT, userSys is the MSB
  localparam int ModeBitUserSys = 5;
  localparam int ModeBitFiq = 4;
  localparam int ModeBitIrq = 3;
  localparam int ModeBitSvc = 2;
  localparam int ModeBitAbort = 1;
  localparam int ModeBitUndef = 0;

  // =========================================================================
  // Register map
  // =========================================================================

  // Architectural registers with special banking
  localparam archRegT FiqLowReg = 4'd8;
  localparam archRegT FiqHighReg = 4'd12;
  localparam archRegT SpReg = 4'd13;
  localparam archRegT LrReg = 4'd14;
  localparam archRegT PcReg = 4'd15;

  // Physical base indices
  localparam logic [PhysIdxWidth-1:0] PhysUserBase = 5'd0;
  localparam logic [PhysIdxWidth-1:0] PhysFiqR8Base = 5'd16;
  localparam logic [PhysIdxWidth-1:0] PhysFiqR13Base = 5'd21;
  localparam logic [PhysIdxWidth-1:0] PhysIrqR13Base = 5'd23;
  localparam logic [PhysIdxWidth-1:0] PhysSvcR13Base = 5'd25;
  localparam logic [PhysIdxWidth-1:0] PhysAbortR13Base = 5'd27;
  localparam logic [PhysIdxWidth-1:0] PhysUndefR13Base = 5'd29;
  // Scratch slot used by multi-cycle sequences
  localparam logic [PhysIdxWidth-1:0] PhysScratch = 5'd31;

endpackage
